// File: common/mem_stage_pkg.sv
package mem_stage_pkg;

    // ======================================
    // Widths fixed by RV32I
    // ======================================
    localparam int XLEN       = 32;              // Data and address width
    localparam int REG_ADDR_W = 5;               // Register index width
    localparam int BYTE_W     = 8;               // Bits per byte lane
    localparam int MASK_W     = XLEN / BYTE_W;   // Byte lanes per word
    localparam int OFFSET_W   = $clog2(MASK_W);  // Byte offset inside a word

    // ======================================
    // funct3 access size codes
    // ======================================
    localparam logic [2:0] F3_BYTE   = 3'b000;   // LB / SB
    localparam logic [2:0] F3_HALF   = 3'b001;   // LH / SH
    localparam logic [2:0] F3_WORD   = 3'b010;   // LW / SW
    localparam logic [2:0] F3_BYTE_U = 3'b100;   // LBU
    localparam logic [2:0] F3_HALF_U = 3'b101;   // LHU

    // ======================================
    // Stage structs
    // ======================================

    // Request handed over from EX
    typedef struct packed {
        logic [XLEN-1:0]       alu_result;      // Effective address
        logic [XLEN-1:0]       store_data;      // rs2 value
        logic [REG_ADDR_W-1:0] rd;              // Destination register
        logic [2:0]            funct3;          // Size and signedness
        logic                  mem_read;        // Load
        logic                  mem_write;       // Store
        logic                  reg_write;       // Writes rd
        logic                  mem_to_reg;      // rd takes load data
    } mem_req_t;

    // Access after address decode
    typedef struct packed {
        logic [XLEN-1:0]     word_addr;         // Word aligned address
        logic [OFFSET_W-1:0] byte_offset;       // Low address bits
        logic [MASK_W-1:0]   mask;              // Lanes touched by the access
        logic [XLEN-1:0]     wdata_shifted;     // Store data in its lanes
        logic [2:0]          funct3;            // Size and signedness
        logic                is_load;           // Valid load
        logic                is_store;          // Valid store
    } mem_access_t;

    // Command to data memory
    typedef struct packed {
        logic [XLEN-1:0]   addr;                // Word address
        logic [XLEN-1:0]   wdata;               // Lane shifted data
        logic [MASK_W-1:0] mask;                // Byte strobes
        logic              ren;                 // Read enable
        logic              wen;                 // Write enable
    } dmem_bus_t;

    // Registered values for WB and EX bypass
    typedef struct packed {
        logic [XLEN-1:0]       alu_result;      // ALU result of the instruction
        logic [REG_ADDR_W-1:0] rd;              // Destination register
        logic                  reg_write;       // Writes rd
        logic                  mem_to_reg;      // rd takes load data
        logic                  valid;           // Instruction present
    } wb_info_t;

endpackage

// File: src/load_align.sv
`timescale 1ns/1ns

module load_align
    import mem_stage_pkg::*;
(
    input  logic [XLEN-1:0]     i_rdata,        // Merged memory word
    input  logic [OFFSET_W-1:0] i_byte_offset,  // Byte offset of the load
    input  logic [2:0]          i_funct3,       // Load size and signedness
    output logic [XLEN-1:0]     o_load_data     // Value for rd
);

    localparam int HALF_W = 2 * BYTE_W;         // Halfword width

    // ======================================
    // Lane select
    // ======================================
    logic [XLEN-1:0]   rdata_shifted;           // Addressed byte moved to lane 0
    logic [BYTE_W-1:0] byte_lane;               // Selected byte
    logic [HALF_W-1:0] half_lane;               // Selected halfword

    assign rdata_shifted = i_rdata >> (i_byte_offset * BYTE_W);
    assign byte_lane     = rdata_shifted[BYTE_W-1:0];

    // Upper or lower halfword from offset bit 1
    assign half_lane = i_byte_offset[1] ? i_rdata[XLEN-1:HALF_W] : i_rdata[HALF_W-1:0];

    // ======================================
    // Extension
    // ======================================
    always_comb begin
        case (i_funct3)
            F3_BYTE: begin
                o_load_data = {{(XLEN-BYTE_W){byte_lane[BYTE_W-1]}}, byte_lane};  // LB
            end
            F3_BYTE_U: begin
                o_load_data = {{(XLEN-BYTE_W){1'b0}}, byte_lane};                 // LBU
            end
            F3_HALF: begin
                o_load_data = {{(XLEN-HALF_W){half_lane[HALF_W-1]}}, half_lane};  // LH
            end
            F3_HALF_U: begin
                o_load_data = {{(XLEN-HALF_W){1'b0}}, half_lane};                 // LHU
            end
            F3_WORD: begin
                o_load_data = i_rdata;                                            // LW
            end
            default: begin
                o_load_data = i_rdata;          // Unused codes read the word
            end
        endcase
    end

endmodule

// File: src/store_forward.sv
`timescale 1ns/1ns

module store_forward
    import mem_stage_pkg::*;
(
    input  logic            i_clk,          // Stage clock
    input  logic            i_rst,          // Sync reset, active high
    input  mem_access_t     i_access,       // Access in the stage now
    input  logic [XLEN-1:0] i_dmem_rdata,   // Word read from memory
    output logic [XLEN-1:0] o_rdata         // Word with newer store bytes
);

    // ======================================
    // One cycle of store history
    // ======================================
    logic [XLEN-1:0]   prev_addr;           // Word address of last access
    logic [XLEN-1:0]   prev_data;           // Its lane shifted data
    logic [MASK_W-1:0] prev_mask;           // Its byte lanes
    logic              prev_valid;          // Last access was a live store

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            prev_valid <= 1'b0;             // Nothing to forward after reset
        end else begin
            prev_valid <= i_access.is_store;
            prev_addr  <= i_access.word_addr;
            prev_data  <= i_access.wdata_shifted;
            prev_mask  <= i_access.mask;
        end
    end

    // ======================================
    // Merge
    // ======================================
    logic forward;                          // Load hits the previous store word

    // Memory has not seen that write yet
    assign forward = prev_valid & i_access.is_load &
                     (prev_addr == i_access.word_addr);

    always_comb begin
        o_rdata = i_dmem_rdata;             // Default memory contents
        for (int lane = 0; lane < MASK_W; lane++) begin
            if (forward && prev_mask[lane]) begin
                o_rdata[lane*BYTE_W +: BYTE_W] = prev_data[lane*BYTE_W +: BYTE_W];
            end
        end
    end

endmodule

// File: src/mem_request_decode.sv
`timescale 1ns/1ns

module mem_request_decode
    import mem_stage_pkg::*;
(
    input  logic        i_clk,              // Stage clock
    input  logic        i_rst,              // Sync reset, active high
    input  logic        i_valid,            // Request strobe
    input  mem_req_t    i_req,              // Request from EX
    output mem_access_t o_access,           // Decoded access
    output dmem_bus_t   o_dmem,             // Memory command
    output wb_info_t    o_wb,               // Registered writeback info
    output logic        o_misaligned        // Misaligned load or store
);

    // ======================================
    // EX/MEM pipeline register
    // ======================================
    mem_req_t req_q;                        // Held request
    logic     valid_q;                      // Held request is live

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            valid_q          <= 1'b0;
            req_q.mem_read   <= 1'b0;       // No access after reset
            req_q.mem_write  <= 1'b0;
            req_q.reg_write  <= 1'b0;       // No rd write after reset
            req_q.mem_to_reg <= 1'b0;
        end else begin
            valid_q <= i_valid;             // Bubble when no request arrives
            if (i_valid) begin
                req_q <= i_req;             // Otherwise contents hold
            end
        end
    end

    // ======================================
    // Address and lane decode
    // ======================================
    logic [XLEN-1:0]     word_addr;         // Address with offset bits cleared
    logic [OFFSET_W-1:0] byte_offset;       // Offset inside the word
    logic [MASK_W-1:0]   byte_mask;         // Lanes for the access size
    logic [XLEN-1:0]     wdata_shifted;     // rs2 moved to its lanes
    logic                is_load;           // Load of a live request
    logic                is_store;          // Store of a live request
    logic                size_word;         // funct3 selects a word
    logic                size_half;         // funct3 selects a halfword

    assign word_addr   = {req_q.alu_result[XLEN-1:OFFSET_W], {OFFSET_W{1'b0}}};
    assign byte_offset = req_q.alu_result[OFFSET_W-1:0];

    assign size_word = (req_q.funct3[1:0] == F3_WORD[1:0]);
    assign size_half = (req_q.funct3[1:0] == F3_HALF[1:0]);   // LH, LHU, SH

    always_comb begin
        case (req_q.funct3[1:0])
            F3_BYTE[1:0]: byte_mask = MASK_W'(4'b0001) << byte_offset;   // One lane
            F3_HALF[1:0]: byte_mask = MASK_W'(4'b0011) << byte_offset;   // Two lanes
            default:      byte_mask = {MASK_W{1'b1}};                    // Whole word
        endcase
    end

    // Offset in bytes scaled to a bit shift
    assign wdata_shifted = req_q.store_data << (byte_offset * BYTE_W);

    assign is_load  = valid_q & req_q.mem_read;
    assign is_store = valid_q & req_q.mem_write;

    // Word with any offset, or halfword on an odd byte
    assign o_misaligned = (is_load | is_store) &
                          ((size_word & (byte_offset != '0)) |
                           (size_half & byte_offset[0]));

    // ======================================
    // Outputs
    // ======================================
    always_comb begin
        o_access.word_addr     = word_addr;
        o_access.byte_offset   = byte_offset;
        o_access.mask          = byte_mask;
        o_access.wdata_shifted = wdata_shifted;
        o_access.funct3        = req_q.funct3;
        o_access.is_load       = is_load;
        o_access.is_store      = is_store;
    end

    always_comb begin
        o_dmem.addr  = word_addr;
        o_dmem.wdata = wdata_shifted;
        o_dmem.mask  = is_store ? byte_mask : '0;   // Strobes only on a write
        o_dmem.ren   = is_load;
        o_dmem.wen   = is_store;
    end

    always_comb begin
        o_wb.alu_result = req_q.alu_result;
        o_wb.rd         = req_q.rd;
        o_wb.reg_write  = req_q.reg_write;
        o_wb.mem_to_reg = req_q.mem_to_reg;
        o_wb.valid      = valid_q;           // Only the valid bit drops on a bubble
    end

endmodule

// File: src/mem_stage.sv
`timescale 1ns/1ns

module mem_stage
    import mem_stage_pkg::*;
(
    input  logic            i_clk,          // Stage clock
    input  logic            i_rst,          // Sync reset, active high

    // Request from EX
    input  logic            i_valid,        // Request strobe
    input  mem_req_t        i_req,          // Request payload

    // Data memory port
    input  logic [XLEN-1:0] i_dmem_rdata,   // Combinational read data
    output dmem_bus_t       o_dmem,         // Memory command

    // Results
    output logic [XLEN-1:0] o_load_data,    // Aligned and extended load value
    output wb_info_t        o_wb,           // Writeback and bypass info
    output logic            o_misaligned    // Misaligned data access
);

    // ======================================
    // Internal wires
    // ======================================
    mem_access_t     access;                // Decoded access of the held request
    logic [XLEN-1:0] merged_rdata;          // Memory word with forwarded bytes

    // ======================================
    // EX/MEM register and decode
    // ======================================
    mem_request_decode u_mem_request_decode (
        .i_clk        (i_clk),
        .i_rst        (i_rst),
        .i_valid      (i_valid),
        .i_req        (i_req),
        .o_access     (access),
        .o_dmem       (o_dmem),
        .o_wb         (o_wb),
        .o_misaligned (o_misaligned)
    );

    // ======================================
    // Store to load forwarding
    // ======================================
    store_forward u_store_forward (
        .i_clk        (i_clk),
        .i_rst        (i_rst),
        .i_access     (access),
        .i_dmem_rdata (i_dmem_rdata),
        .o_rdata      (merged_rdata)
    );

    // ======================================
    // Load lane select and extension
    // ======================================
    load_align u_load_align (
        .i_rdata       (merged_rdata),
        .i_byte_offset (access.byte_offset),
        .i_funct3      (access.funct3),
        .o_load_data   (o_load_data)
    );

endmodule

// File: test/tb_mem_stage.sv
`timescale 1ns/1ns

module tb_mem_stage
    import mem_stage_pkg::*;
();

    // ========================================
    // Run length and timing
    // ========================================
    localparam int CLK_PERIOD  = 8;                        // ns
    localparam int RESET_CYC   = 16;                       // Cycles in reset
    localparam int N_DIRECTED  = 100;                      // Upper bound of directed ops
    localparam int N_RANDOM    = 200;                      // Random ops
    localparam int N_OPS       = N_DIRECTED + N_RANDOM;
    localparam int WATCHDOG_NS = (N_OPS + 40) * CLK_PERIOD;
    localparam int MEM_WORDS   = 64;                       // Memory model depth

    logic            i_clk;
    logic            i_rst;
    logic            i_valid;
    mem_req_t        i_req;
    logic [XLEN-1:0] i_dmem_rdata;
    dmem_bus_t       o_dmem;
    logic [XLEN-1:0] o_load_data;
    wb_info_t        o_wb;
    logic            o_misaligned;

    integer seed = 32'h4391_939a;                          // Fixed random seed

    mem_stage i_mem_stage (
        .i_clk        (i_clk),
        .i_rst        (i_rst),
        .i_valid      (i_valid),
        .i_req        (i_req),
        .i_dmem_rdata (i_dmem_rdata),
        .o_dmem       (o_dmem),
        .o_load_data  (o_load_data),
        .o_wb         (o_wb),
        .o_misaligned (o_misaligned)
    );

    initial begin
        i_clk = 1'b0;
        forever #(CLK_PERIOD / 2) i_clk = ~i_clk;
    end

    // ========================================
    // Memory model with one edge write delay
    // ========================================
    logic [XLEN-1:0]   mem_model [MEM_WORDS];
    logic              pend_valid = 1'b0;                  // Write waiting to commit
    logic [5:0]        pend_idx;
    logic [XLEN-1:0]   pend_data;
    logic [MASK_W-1:0] pend_mask;

    initial begin
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem_model[i] = (32'(i) * 32'h0405_0607) ^ 32'hc3a5_8e71;   // Unique per word
        end
    end

    assign i_dmem_rdata = mem_model[o_dmem.addr[7:2]];    // Combinational read

    always @(posedge i_clk) begin
        if (pend_valid) begin
            for (int l = 0; l < MASK_W; l++) begin
                if (pend_mask[l]) begin
                    mem_model[pend_idx][l*8 +: 8] = pend_data[l*8 +: 8];
                end
            end
        end
        pend_valid <= o_dmem.wen && !i_rst;                // Seen now, committed next edge
        pend_idx   <= o_dmem.addr[7:2];
        pend_data  <= o_dmem.wdata;
        pend_mask  <= o_dmem.mask;
    end

    // ========================================
    // Reference rules
    // ========================================
    function automatic int access_bytes(input logic [2:0] f3);
        case (f3[1:0])
            2'b00:   return 1;
            2'b01:   return 2;
            default: return 4;
        endcase
    endfunction

    // Lane l is written when it lies inside the accessed bytes
    function automatic logic [MASK_W-1:0] exp_mask(input logic [2:0] f3, input logic [1:0] off);
        logic [MASK_W-1:0] m;
        for (int l = 0; l < MASK_W; l++) begin
            m[l] = (l >= int'(off)) && (l < int'(off) + access_bytes(f3));
        end
        return m;
    endfunction

    // Store byte i lands in lane off + i and lower lanes stay zero
    function automatic logic [XLEN-1:0] exp_wdata(input logic [XLEN-1:0] d,
                                                  input logic [1:0] off);
        logic [XLEN-1:0] w;
        w = '0;
        for (int l = int'(off); l < MASK_W; l++) begin
            w[l*8 +: 8] = d[(l - int'(off))*8 +: 8];
        end
        return w;
    endfunction

    function automatic logic misaligned_rule(input logic [2:0] f3, input logic [1:0] off);
        case (f3)
            F3_WORD:            return off != 2'b00;
            F3_HALF, F3_HALF_U: return off[0];
            default:            return 1'b0;
        endcase
    endfunction

    // Architected load value, with the previous store overlaid
    function automatic logic [XLEN-1:0] exp_load(input logic [XLEN-1:0] mem_word,
                                                 input logic fwd_valid,
                                                 input logic [XLEN-1:0] fwd_addr,
                                                 input logic [MASK_W-1:0] fwd_mask,
                                                 input logic [XLEN-1:0] fwd_data,
                                                 input logic [XLEN-1:0] addr,
                                                 input logic [2:0] f3);
        logic [XLEN-1:0] word;
        logic [7:0]      b;
        logic [15:0]     h;
        word = mem_word;
        if (fwd_valid && fwd_addr == {addr[31:2], 2'b00}) begin
            for (int l = 0; l < MASK_W; l++) begin
                if (fwd_mask[l]) word[l*8 +: 8] = fwd_data[l*8 +: 8];
            end
        end
        b = word[8*addr[1:0] +: 8];
        h = addr[1] ? word[31:16] : word[15:0];
        case (f3)
            F3_BYTE:   return {{24{b[7]}}, b};
            F3_BYTE_U: return {24'h0, b};
            F3_HALF:   return {{16{h[15]}}, h};
            F3_HALF_U: return {16'h0, h};
            default:   return word;
        endcase
    endfunction

    // ========================================
    // Expected stage contents
    // ========================================
    logic              started = 1'b0;                     // First edge seen
    logic              have_req = 1'b0;                    // Some valid request taken
    logic              exp_valid = 1'b0;
    mem_req_t          exp_req;
    logic              prev_st_valid = 1'b0;               // Store in stage last cycle
    logic              prev_st_mis;
    logic [XLEN-1:0]   prev_st_addr;
    logic [MASK_W-1:0] prev_st_mask;
    logic [XLEN-1:0]   prev_st_data;

    always @(posedge i_clk) begin
        started       <= 1'b1;
        prev_st_valid <= !i_rst && exp_valid && exp_req.mem_write;
        prev_st_mis   <= misaligned_rule(exp_req.funct3, exp_req.alu_result[1:0]);
        prev_st_addr  <= {exp_req.alu_result[31:2], 2'b00};
        prev_st_mask  <= exp_mask(exp_req.funct3, exp_req.alu_result[1:0]);
        prev_st_data  <= exp_wdata(exp_req.store_data, exp_req.alu_result[1:0]);
        if (i_rst) begin
            exp_valid          <= 1'b0;
            exp_req.mem_read   <= 1'b0;
            exp_req.mem_write  <= 1'b0;
            exp_req.reg_write  <= 1'b0;
            exp_req.mem_to_reg <= 1'b0;
        end else begin
            exp_valid <= i_valid;
            if (i_valid) begin
                exp_req  <= i_req;                         // Held while i_valid is low
                have_req <= 1'b1;
            end
        end
    end

    // ========================================
    // Checker
    // ========================================
    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Test failures found");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [XLEN-1:0] got,
                               input logic [XLEN-1:0] exp);
        assert (got === exp) else
            abort_run($sformatf("Error: %s got 0x%h expected 0x%h at %0t", name, got, exp, $time));
    endtask

    task automatic check_outputs();
        logic [1:0] off;
        logic       is_ld;
        logic       is_st;
        logic       mis;
        logic       fwd_bad;
        off   = exp_req.alu_result[1:0];
        is_ld = exp_valid && exp_req.mem_read;
        is_st = exp_valid && exp_req.mem_write;
        mis   = (is_ld || is_st) && misaligned_rule(exp_req.funct3, off);
        check_value("o_wb.valid", o_wb.valid, exp_valid);
        check_value("o_dmem.ren", o_dmem.ren, is_ld);
        check_value("o_dmem.wen", o_dmem.wen, is_st);
        check_value("o_misaligned", o_misaligned, mis);
        check_value("o_wb.reg_write", o_wb.reg_write, exp_req.reg_write);
        check_value("o_wb.mem_to_reg", o_wb.mem_to_reg, exp_req.mem_to_reg);
        if (have_req) begin
            check_value("o_wb.alu_result", o_wb.alu_result, exp_req.alu_result);
            check_value("o_wb.rd", o_wb.rd, exp_req.rd);
            check_value("o_dmem.addr", o_dmem.addr, {exp_req.alu_result[31:2], 2'b00});
        end
        if (is_st && !mis) begin
            check_value("o_dmem.mask", o_dmem.mask, exp_mask(exp_req.funct3, off));
            check_value("o_dmem.wdata", o_dmem.wdata, exp_wdata(exp_req.store_data, off));
        end else if (!is_st) begin
            check_value("o_dmem.mask", o_dmem.mask, '0);   // No strobes without a write
        end
        // Forwarded bytes of a misaligned store have no defined value
        fwd_bad = prev_st_valid && prev_st_mis &&
                  (prev_st_addr == {exp_req.alu_result[31:2], 2'b00});
        if (is_ld && !mis && !fwd_bad) begin
            check_value("o_load_data", o_load_data,
                        exp_load(mem_model[exp_req.alu_result[7:2]], prev_st_valid,
                                 prev_st_addr, prev_st_mask, prev_st_data,
                                 exp_req.alu_result, exp_req.funct3));
        end
    endtask

    always @(negedge i_clk) begin
        if (started) check_outputs();                      // Outputs settled mid cycle
    end

    initial begin
        #(WATCHDOG_NS);
        abort_run("Timeout: the run did not finish within the expected time");
    end

    // ========================================
    // Stimulus
    // ========================================
    function automatic logic [XLEN-1:0] addr_of(input int word, input int off);
        return 32'(word * 4 + off);
    endfunction

    task automatic send(input logic valid, input logic [XLEN-1:0] addr,
                        input logic [2:0] f3, input logic rd_en, input logic wr_en);
        mem_req_t req;
        req.alu_result = addr;
        req.store_data = $random(seed);
        req.rd         = 5'($random(seed));
        req.funct3     = f3;
        req.mem_read   = rd_en;
        req.mem_write  = wr_en;
        req.reg_write  = !wr_en;                           // Loads and ALU ops write rd
        req.mem_to_reg = rd_en;
        @(posedge i_clk);
        i_valid <= valid;
        i_req   <= req;
    endtask

    task automatic bubble();
        send(1'b0, $random(seed), F3_WORD, 1'b1, 1'b1);    // Junk payload must be ignored
    endtask

    task automatic alu_op();
        send(1'b1, $random(seed), F3_WORD, 1'b0, 1'b0);
    endtask

    task automatic sweep_offsets(input logic [2:0] f3, input logic is_store,
                                 input logic legal_only, input int word);
        int step;
        step = legal_only ? access_bytes(f3) : 1;
        for (int off = 0; off < 4; off += step) begin
            send(1'b1, addr_of(word, off), f3, !is_store, is_store);
        end
    endtask

    function automatic logic [2:0] pick_code(input int i);
        case (i % 5)
            0:       return F3_BYTE;
            1:       return F3_HALF;
            2:       return F3_WORD;
            3:       return F3_BYTE_U;
            default: return F3_HALF_U;
        endcase
    endfunction

    initial begin
        logic [31:0] r;
        logic [2:0]  f3;
        logic [1:0]  off;
        i_rst   = 1'b1;
        i_valid = 1'b0;
        i_req   = '0;
        repeat (RESET_CYC) @(posedge i_clk);
        i_rst <= 1'b0;

        // Stores at legal offsets
        sweep_offsets(F3_BYTE, 1'b1, 1'b1, 4);
        sweep_offsets(F3_HALF, 1'b1, 1'b1, 5);
        sweep_offsets(F3_WORD, 1'b1, 1'b1, 6);
        bubble();

        // Loads at legal offsets
        for (int i = 0; i < 5; i++) sweep_offsets(pick_code(i), 1'b0, 1'b1, 4 + i % 3);

        // Forwarding from the store one cycle earlier
        send(1'b1, addr_of(20, 2), F3_BYTE, 1'b0, 1'b1);
        send(1'b1, addr_of(20, 0), F3_WORD, 1'b1, 1'b0);
        send(1'b1, addr_of(21, 2), F3_HALF, 1'b0, 1'b1);
        send(1'b1, addr_of(21, 2), F3_HALF, 1'b1, 1'b0);
        send(1'b1, addr_of(22, 0), F3_WORD, 1'b0, 1'b1);
        send(1'b1, addr_of(23, 1), F3_BYTE_U, 1'b1, 1'b0); // Other word reads memory
        send(1'b1, addr_of(22, 3), F3_BYTE, 1'b1, 1'b0);   // Write committed by now
        send(1'b1, addr_of(24, 0), F3_WORD, 1'b0, 1'b1);
        bubble();
        send(1'b1, addr_of(24, 2), F3_HALF_U, 1'b1, 1'b0);

        // Misalignment at every offset
        for (int i = 0; i < 5; i++) sweep_offsets(pick_code(i), 1'b0, 1'b0, 30);
        for (int i = 0; i < 3; i++) sweep_offsets(pick_code(i), 1'b1, 1'b0, 31);
        alu_op();
        alu_op();

        // Valid strobe and writeback hold
        alu_op();
        bubble();
        bubble();
        sweep_offsets(F3_WORD, 1'b0, 1'b1, 8);
        bubble();
        alu_op();

        // Random mix
        for (int n = 0; n < N_RANDOM; n++) begin
            r   = $random(seed);
            f3  = pick_code(int'(r[10:8]));
            off = r[13:12];
            if (r[11] || r[1:0] == 2'd2) off = off & ~2'(access_bytes(f3) - 1);
            if (r[4:2] == 3'd0) begin
                bubble();
            end else if (r[1:0] == 2'd2) begin
                send(1'b1, addr_of(int'(r[17:14]), off), {1'b0, f3[1:0]}, 1'b0, 1'b1);
            end else if (r[1:0] == 2'd3) begin
                alu_op();
            end else begin
                send(1'b1, addr_of(int'(r[17:14]), off), f3, 1'b1, 1'b0);
            end
        end

        bubble();
        repeat (3) @(negedge i_clk);                       // Last checks done
        $display("All tests passed!");
        $finish;
    end

endmodule

// File: files.f
common/mem_stage_pkg.sv
src/load_align.sv
src/store_forward.sv
src/mem_request_decode.sv
src/mem_stage.sv
test/tb_mem_stage.sv
